// File: compile.f
+incdir+design
design/vdpu_pkg.sv
design/operand_gather.sv
design/lane_alu.sv
design/slide_network.sv
design/result_scatter.sv
design/v_dpu_top.sv
verification/tb_v_dpu.sv

// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= compile.f
TB_TOP    ?= tb_v_dpu
RTL_TOP   ?= v_dpu_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert -Wno-fatal
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	-./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "Simulation incomplete"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: verification/tb_v_dpu.sv
`timescale 1ns/1ps
`include "vdpu_settings.svh"

module tb_v_dpu;
   import vdpu_pkg::*;

   localparam int N_DIRECTED = 6;
   localparam int N_ALU      = 180;   // 3 SEW x 5 ops x 3 selects x 4
   localparam int N_SLIDE    = 16;
   localparam int N_STALL    = 200;
   localparam int N_TOTAL    = N_DIRECTED + N_ALU + N_SLIDE + N_STALL;
   localparam int CYCLE_LIMIT = 4 * N_TOTAL + 16 + 200;

   logic                     clk_i;
   logic                     rst_i;
   logic                     in_valid_i;
   logic                     ready_o;
   alu_op_e                  op_i;
   sew_e                     sew_i;
   op2_sel_e                 op2_sel_i;
   logic [`VDPU_WORD_W-1:0]  x_data_i;
   logic [`VDPU_IMM_W-1:0]   imm_i;
   logic [`VDPU_SLIDE_W-1:0] slide_amt_i;
   lane_vec_t                vs1_i, vs2_i;
   logic                     out_valid_o;
   logic                     out_ready_i;
   lane_vec_t                vd_o;

   lane_vec_t   exp_q[$];
   int          acc_q[$];
   int          cycles = 0;
   int          error_count = 0;
   logic [31:0] rng = 32'h7920;
   logic [31:0] stall_rng;
   logic        stall_mode = 1'b0;
   logic        check_latency = 1'b1;
   logic        held = 1'b0;
   lane_vec_t   held_vd;

   v_dpu_top DUT (
      .clk_i(clk_i), .rst_i(rst_i), .in_valid_i(in_valid_i), .ready_o(ready_o),
      .op_i(op_i), .sew_i(sew_i), .op2_sel_i(op2_sel_i), .x_data_i(x_data_i),
      .imm_i(imm_i), .slide_amt_i(slide_amt_i), .vs1_i(vs1_i), .vs2_i(vs2_i),
      .out_valid_o(out_valid_o), .out_ready_i(out_ready_i), .vd_o(vd_o)
   );

   always #4 clk_i = ~clk_i;   // 8 ns period

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] v;
      v = s ^ (s << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function logic [31:0] rand32();
      rng = xorshift(rng);
      return rng;
   endfunction

   //////////////////////////////////////////////////
   // Reference model from the byte layout rules
   //////////////////////////////////////////////////

   function automatic lane_vec_t expected_vd(input alu_op_e op, input sew_e sew,
      input op2_sel_e sel, input logic [31:0] x, input logic [4:0] imm,
      input logic [2:0] amt, input lane_vec_t vs1, input lane_vec_t vs2);
      lane_vec_t   res;
      logic [31:0] a, b, r, scal, mask;
      int          s, n, p;
      res = '0;
      if (op == OP_SLIDEUP || op == OP_SLIDEDN)
      begin
         // Source lane i lands amt lanes higher for up, lower for down
         for (int i = 0; i < `VDPU_LANES; i++)
         begin
            if (op == OP_SLIDEUP)
               res[(i + int'(amt)) % 8] = vs2[i];
            else
               res[(i + 8 - int'(amt)) % 8] = vs2[i];
         end
         return res;
      end
      s    = (sew == SEW8) ? 1 : (sew == SEW16) ? 2 : 4;
      n    = (sew == SEW8) ? 32 : 8;   // SEW16 keeps elements 0..7 only
      mask = (s == 4) ? 32'hffff_ffff : ((32'h1 << (8 * s)) - 32'h1);
      scal = (sel == SRC_IMM) ? {{27{imm[4]}}, imm} : x;
      for (int k = 0; k < n; k++)
      begin
         a = '0;
         b = '0;
         for (int j = 0; j < s; j++)
         begin
            p = k * s + j;
            a[8*j +: 8] = vs1[p % 8].bytes[p / 8];
            b[8*j +: 8] = vs2[p % 8].bytes[p / 8];
         end
         if (sel != SRC_VS2)
            b = scal & mask;
         case (op)
            OP_ADD:  r = a + b;
            OP_SUB:  r = a - b;
            OP_AND:  r = a & b;
            OP_OR:   r = a | b;
            default: r = a ^ b;
         endcase
         r = r & mask;
         for (int j = 0; j < s; j++)
         begin
            p = k * s + j;
            res[p % 8].bytes[p / 8] = r[8*j +: 8];
         end
      end
      if (sew == SEW16)
      begin
         for (int l = 0; l < `VDPU_LANES; l++)
            res[l].word[31:16] = res[l].word[15:0];   // Byte indexes 2-3 mirror 0-1
      end
      return res;
   endfunction

   task automatic abort_run();
      $display("Finished with errors");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check(input string name, input logic [255:0] got, input logic [255:0] exp);
      if (got !== exp)
      begin
         error_count++;
         $display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, exp);
         abort_run();
      end
   endtask

   // Caller sits on a rising edge; returns on the accepting edge
   task automatic send(input alu_op_e op, input sew_e sew, input op2_sel_e sel,
      input logic [31:0] x, input logic [4:0] imm, input logic [2:0] amt,
      input lane_vec_t vs1, input lane_vec_t vs2);
      op_i        <= op;
      sew_i       <= sew;
      op2_sel_i   <= sel;
      x_data_i    <= x;
      imm_i       <= imm;
      slide_amt_i <= amt;
      vs1_i       <= vs1;
      vs2_i       <= vs2;
      in_valid_i  <= 1'b1;
      @(posedge clk_i);
      while (!ready_o)
         @(posedge clk_i);
   endtask

   task automatic send_random(input alu_op_e op, input sew_e sew, input op2_sel_e sel,
      input logic [2:0] amt);
      lane_vec_t   v1;
      lane_vec_t   v2;
      logic [31:0] r;
      for (int l = 0; l < `VDPU_LANES; l++)
      begin
         v1[l].word = rand32();
         v2[l].word = rand32();
      end
      r = rand32();
      send(op, sew, sel, rand32(), r[4:0], amt, v1, v2);
   endtask

   task automatic drain();
      in_valid_i <= 1'b0;
      @(posedge clk_i);
      while (exp_q.size() != 0)
         @(posedge clk_i);
      repeat (2) @(posedge clk_i);
   endtask

   //////////////////////////////////////////////////
   // Scoreboard, back-pressure and timeout
   //////////////////////////////////////////////////

   always @(posedge clk_i)
   begin
      if (rst_i && in_valid_i && ready_o)
      begin
         exp_q.push_back(expected_vd(op_i, sew_i, op2_sel_i, x_data_i, imm_i,
                                     slide_amt_i, vs1_i, vs2_i));
         acc_q.push_back(cycles);
      end
   end

   always @(posedge clk_i)
   begin
      if (rst_i)
      begin
         if (check_latency)
            check("ready_o", ready_o, 1'b1);   // No back-pressure in this phase
         if (held)
         begin
            check("out_valid_o", out_valid_o, 1'b1);   // Must hold while stalled
            check("vd_o", vd_o, held_vd);
         end
         if (out_valid_o && out_ready_i)
         begin
            if (exp_q.size() == 0)
            begin
               $display("Result taken at %0t with no expected value pending", $time);
               abort_run();
            end
            else
            begin
               check("vd_o", vd_o, exp_q.pop_front());
               if (check_latency)
                  check("latency", 256'(cycles - acc_q[0]), 256'd3);
               void'(acc_q.pop_front());
            end
         end
         held    = out_valid_o && !out_ready_i;
         held_vd = vd_o;
      end
   end

   always @(posedge clk_i)
   begin
      if (stall_mode)
      begin
         stall_rng = xorshift(stall_rng);
         out_ready_i <= stall_rng[4];
      end
      else
         out_ready_i <= 1'b1;
   end

   always @(posedge clk_i)
   begin
      cycles <= cycles + 1;
      if (cycles >= CYCLE_LIMIT)
      begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         abort_run();
      end
   end

   initial
   begin
      logic [31:0] r;
      clk_i       = 1'b0;
      rst_i       = 1'b0;
      in_valid_i  = 1'b0;
      op_i        = OP_ADD;
      sew_i       = SEW8;
      op2_sel_i   = SRC_VS2;
      x_data_i    = '0;
      imm_i       = '0;
      slide_amt_i = '0;
      vs1_i       = '0;
      vs2_i       = '0;
      out_ready_i = 1'b1;
      stall_rng   = xorshift(32'h7920);
      repeat (16) @(posedge clk_i);
      rst_i <= 1'b1;
      @(negedge clk_i);
      check("out_valid_o", out_valid_o, 1'b0);
      check("ready_o", ready_o, 1'b1);
      @(posedge clk_i);

      // Wrap-around corners and then random ALU ops back to back
      for (int s = 0; s < 3; s++)
      begin
         send(OP_ADD, sew_e'(s), SRC_IMM, '0, 5'h01, '0, {8{32'hffff_ffff}}, '0);
         send(OP_SUB, sew_e'(s), SRC_VS2, '0, '0, '0, '0, {8{32'h0001_0001}});
      end
      for (int s = 0; s < 3; s++)
         for (int o = 0; o < 5; o++)
            for (int c = 0; c < 3; c++)
               repeat (4) send_random(alu_op_e'(o), sew_e'(s), op2_sel_e'(c), '0);

      for (int d = 0; d < 2; d++)
         for (int a = 0; a < 8; a++)
         begin
            r = rand32();
            send_random(d ? OP_SLIDEUP : OP_SLIDEDN, sew_e'(r[1:0] % 2'd3),
                        op2_sel_e'(r[5:4] % 2'd3), 3'(a));
         end
      drain();

      // Random mix under back-pressure
      check_latency <= 1'b0;
      stall_mode    <= 1'b1;
      @(posedge clk_i);
      repeat (N_STALL)
      begin
         r = rand32();
         send_random(alu_op_e'(r[2:0] % 3'd7), sew_e'(r[9:8] % 2'd3),
                     op2_sel_e'(r[17:16] % 2'd3), r[26:24]);
      end
      drain();

      if (error_count == 0)
      begin
         $display("Finished with no errors");
         $finish;
      end
      else
         abort_run();
   end

endmodule

// File: design/v_dpu_top.sv
`timescale 1ns/1ps
`include "vdpu_settings.svh"

module v_dpu_top
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     in_valid_i,
   output logic                     ready_o,
   input  vdpu_pkg::alu_op_e        op_i,
   input  vdpu_pkg::sew_e           sew_i,
   input  vdpu_pkg::op2_sel_e       op2_sel_i,
   input  logic [`VDPU_WORD_W-1:0]  x_data_i,
   input  logic [`VDPU_IMM_W-1:0]   imm_i,
   input  logic [`VDPU_SLIDE_W-1:0] slide_amt_i,
   input  vdpu_pkg::lane_vec_t      vs1_i,
   input  vdpu_pkg::lane_vec_t      vs2_i,
   output logic                     out_valid_o,
   input  logic                     out_ready_i,
   output vdpu_pkg::lane_vec_t      vd_o
);
   import vdpu_pkg::*;

   logic                     advance;
   logic                     s1_valid;
   alu_op_e                  s1_op;
   sew_e                     s1_sew;
   logic [`VDPU_SLIDE_W-1:0] s1_slide_amt;
   logic                     s1_up;
   lane_vec_t                s1_opa, s1_opb, s1_vs2;
   lane_vec_t                alu_res;
   logic                     slide_valid;
   lane_vec_t                slide_res;
   alu_op_e                  s2_op;   // Travels beside the stage 2 results
   sew_e                     s2_sew;

   // One stall for the whole pipe
   assign advance = !(out_valid_o && !out_ready_i);
   assign ready_o = advance;

   operand_gather u_gather (
      .clk_i(clk_i), .rst_i(rst_i), .advance_i(advance), .in_valid_i(in_valid_i),
      .op_i(op_i), .sew_i(sew_i), .op2_sel_i(op2_sel_i), .x_data_i(x_data_i),
      .imm_i(imm_i), .slide_amt_i(slide_amt_i), .vs1_i(vs1_i), .vs2_i(vs2_i),
      .valid_o(s1_valid), .op_o(s1_op), .sew_o(s1_sew), .slide_amt_o(s1_slide_amt),
      .up_o(s1_up), .opa_o(s1_opa), .opb_o(s1_opb), .vs2_o(s1_vs2)
   );

   //////////////////////////////////////////////////
   // Stage 2 ALU lanes and slide network in parallel
   //////////////////////////////////////////////////

   for (genvar l = 0; l < `VDPU_LANES; l++)
   begin : g_lane
      lane_alu u_alu (
         .clk_i(clk_i), .rst_i(rst_i), .advance_i(advance), .valid_i(s1_valid),
         .op_i(s1_op), .sew_i(s1_sew), .opa_i(s1_opa[l]), .opb_i(s1_opb[l]),
         .valid_o(), .res_o(alu_res[l])
      );
   end

   slide_network u_slide (
      .clk_i(clk_i), .rst_i(rst_i), .advance_i(advance), .valid_i(s1_valid),
      .up_i(s1_up), .amt_i(s1_slide_amt), .vs2_i(s1_vs2),
      .valid_o(slide_valid), .res_o(slide_res)
   );

   always_ff @(posedge clk_i)
   begin
      if (advance)
      begin
         s2_op  <= s1_op;
         s2_sew <= s1_sew;
      end
   end

   result_scatter u_scatter (
      .clk_i(clk_i), .rst_i(rst_i), .advance_i(advance), .valid_i(slide_valid),
      .op_i(s2_op), .sew_i(s2_sew), .alu_res_i(alu_res), .slide_res_i(slide_res),
      .valid_o(out_valid_o), .vd_o(vd_o)
   );

   // Output frozen until taken
   a_out_stable : assert property (@(posedge clk_i) disable iff (!rst_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(vd_o));

endmodule

// File: design/result_scatter.sv
`timescale 1ns/1ps
`include "vdpu_settings.svh"

module result_scatter
(
   input  logic                clk_i,
   input  logic                rst_i,
   input  logic                advance_i,
   input  logic                valid_i,
   input  vdpu_pkg::alu_op_e   op_i,
   input  vdpu_pkg::sew_e      sew_i,
   input  vdpu_pkg::lane_vec_t alu_res_i,
   input  vdpu_pkg::lane_vec_t slide_res_i,
   output logic                valid_o,
   output vdpu_pkg::lane_vec_t vd_o
);
   import vdpu_pkg::*;

   lane_vec_t scat;

   // Element bytes back to position p: lane p mod 8, byte p div 8
   always_comb
   begin
      int p;
      scat = '0;
      case (sew_i)
         SEW8:
            scat = alu_res_i;
         SEW16:
         begin
            for (int g = 0; g < `VDPU_LANES; g++)
            begin
               for (int j = 0; j < 2; j++)
               begin
                  p = 2 * g + j;
                  scat[p % `VDPU_LANES].bytes[p / `VDPU_LANES]     = alu_res_i[g].bytes[j];
                  scat[p % `VDPU_LANES].bytes[p / `VDPU_LANES + 2] = alu_res_i[g].bytes[j];
               end
            end
         end
         default:
         begin
            for (int g = 0; g < `VDPU_LANES; g++)
            begin
               for (int j = 0; j < 4; j++)
               begin
                  p = 4 * g + j;
                  scat[p % `VDPU_LANES].bytes[p / `VDPU_LANES] = alu_res_i[g].bytes[j];
               end
            end
         end
      endcase

      // Slide words are already in place
      if (op_i == OP_SLIDEUP || op_i == OP_SLIDEDN)
         scat = slide_res_i;
   end

   //////////////////////////////////////////////////
   // Output register
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else if (advance_i)
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (advance_i)
         vd_o <= scat;   // Held during a stall
   end

endmodule

// File: design/slide_network.sv
`timescale 1ns/1ps
`include "vdpu_settings.svh"

module slide_network
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     advance_i,
   input  logic                     valid_i,
   input  logic                     up_i,
   input  logic [`VDPU_SLIDE_W-1:0] amt_i,
   input  vdpu_pkg::lane_vec_t      vs2_i,
   output logic                     valid_o,
   output vdpu_pkg::lane_vec_t      res_o
);
   import vdpu_pkg::*;

   lane_vec_t rot;

   // Rotation across lanes, wraps at the lane count
   always_comb
   begin
      for (int l = 0; l < `VDPU_LANES; l++)
      begin
         if (up_i)
            rot[l] = vs2_i[(l + `VDPU_LANES - int'(amt_i)) % `VDPU_LANES];
         else
            rot[l] = vs2_i[(l + int'(amt_i)) % `VDPU_LANES];
      end
   end

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else if (advance_i)
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (advance_i)
         res_o <= rot;   // Whole words move, no byte shuffle
   end

endmodule

// File: design/lane_alu.sv
`timescale 1ns/1ps
`include "vdpu_settings.svh"

module lane_alu
(
   input  logic                 clk_i,
   input  logic                 rst_i,
   input  logic                 advance_i,
   input  logic                 valid_i,
   input  vdpu_pkg::alu_op_e    op_i,
   input  vdpu_pkg::sew_e       sew_i,
   input  vdpu_pkg::lane_word_u opa_i,
   input  vdpu_pkg::lane_word_u opb_i,
   output logic                 valid_o,
   output vdpu_pkg::lane_word_u res_o
);
   import vdpu_pkg::*;

   lane_word_u              res_d;
   logic [`VDPU_WORD_W-1:0] tmp;

   // Narrow elements come in zero-extended, the caller keeps the low bits
   function automatic logic [`VDPU_WORD_W-1:0] elem_op
   (
      input alu_op_e                 op,
      input logic [`VDPU_WORD_W-1:0] a,
      input logic [`VDPU_WORD_W-1:0] b
   );
      case (op)
         OP_ADD:  elem_op = a + b;
         OP_SUB:  elem_op = a - b;
         OP_AND:  elem_op = a & b;
         OP_OR:   elem_op = a | b;
         OP_XOR:  elem_op = a ^ b;
         default: elem_op = a;   // Slides go through the network
      endcase
   endfunction

   always_comb
   begin
      res_d = '0;
      tmp   = '0;
      case (sew_i)
         SEW8:
         begin
            // Four independent byte elements
            for (int i = 0; i < 4; i++)
            begin
               tmp = elem_op(op_i, {24'h0, opa_i.bytes[i]}, {24'h0, opb_i.bytes[i]});
               res_d.bytes[i] = tmp[7:0];
            end
         end
         SEW16:
         begin
            tmp = elem_op(op_i, {16'h0, opa_i.word[15:0]}, {16'h0, opb_i.word[15:0]});
            res_d.word = {16'h0, tmp[15:0]};   // Upper half stays zero
         end
         default:
            res_d.word = elem_op(op_i, opa_i.word, opb_i.word);
      endcase
   end

   //////////////////////////////////////////////////
   // Stage 2 register
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else if (advance_i)
         valid_o <= valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (advance_i)
         res_o <= res_d;
   end

   a_op_legal : assert property (@(posedge clk_i) disable iff (!rst_i)
      valid_i |-> op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLIDEUP, OP_SLIDEDN});

endmodule

// File: design/operand_gather.sv
`timescale 1ns/1ps
`include "vdpu_settings.svh"

module operand_gather
(
   input  logic                     clk_i,
   input  logic                     rst_i,
   input  logic                     advance_i,
   input  logic                     in_valid_i,
   input  vdpu_pkg::alu_op_e        op_i,
   input  vdpu_pkg::sew_e           sew_i,
   input  vdpu_pkg::op2_sel_e       op2_sel_i,
   input  logic [`VDPU_WORD_W-1:0]  x_data_i,
   input  logic [`VDPU_IMM_W-1:0]   imm_i,
   input  logic [`VDPU_SLIDE_W-1:0] slide_amt_i,
   input  vdpu_pkg::lane_vec_t      vs1_i,
   input  vdpu_pkg::lane_vec_t      vs2_i,
   output logic                     valid_o,
   output vdpu_pkg::alu_op_e        op_o,
   output vdpu_pkg::sew_e           sew_o,
   output logic [`VDPU_SLIDE_W-1:0] slide_amt_o,
   output logic                     up_o,
   output vdpu_pkg::lane_vec_t      opa_o,
   output vdpu_pkg::lane_vec_t      opb_o,
   output vdpu_pkg::lane_vec_t      vs2_o
);
   import vdpu_pkg::*;

   lane_vec_t               grp_a;
   lane_vec_t               grp_b;
   lane_vec_t               opb_d;
   lane_word_u              scalar_b;
   logic [`VDPU_WORD_W-1:0] imm_sext;

   // Lane g collects the bytes of element g from the striped layout
   always_comb
   begin
      int p;
      int nb;
      nb    = (sew_i == SEW16) ? 2 : 4;
      grp_a = '0;
      grp_b = '0;
      for (int g = 0; g < `VDPU_LANES; g++)
      begin
         for (int j = 0; j < 4; j++)
         begin
            p = g * nb + j;
            if (j < nb)
            begin
               grp_a[g].bytes[j] = vs1_i[p % `VDPU_LANES].bytes[p / `VDPU_LANES];
               grp_b[g].bytes[j] = vs2_i[p % `VDPU_LANES].bytes[p / `VDPU_LANES];
            end
         end
      end
      if (sew_i == SEW8)
      begin
         grp_a = vs1_i;   // Own four bytes already
         grp_b = vs2_i;
      end
   end

   assign imm_sext = {{(`VDPU_WORD_W-`VDPU_IMM_W){imm_i[`VDPU_IMM_W-1]}}, imm_i};

   // Scalar operand fitted to the element width
   always_comb
   begin
      logic [`VDPU_WORD_W-1:0] val;
      val = (op2_sel_i == SRC_IMM) ? imm_sext : x_data_i;
      case (sew_i)
         SEW8:    scalar_b.bytes = {4{val[7:0]}};
         SEW16:   scalar_b.word  = {16'h0, val[15:0]};
         default: scalar_b.word  = val;
      endcase
   end

   always_comb
   begin
      for (int l = 0; l < `VDPU_LANES; l++)
         opb_d[l] = (op2_sel_i == SRC_VS2) ? grp_b[l] : scalar_b;
   end

   //////////////////////////////////////////////////
   // Stage 1 register
   //////////////////////////////////////////////////

   always_ff @(posedge clk_i)
   begin
      if (!rst_i)
         valid_o <= 1'b0;
      else if (advance_i)
         valid_o <= in_valid_i;
   end

   always_ff @(posedge clk_i)
   begin
      if (advance_i && in_valid_i)
      begin
         op_o        <= op_i;
         sew_o       <= sew_i;
         slide_amt_o <= slide_amt_i;
         up_o        <= (op_i == OP_SLIDEUP);   // Slide direction decoded here only
         opa_o       <= grp_a;
         opb_o       <= opb_d;
         vs2_o       <= vs2_i;
      end
   end

   // Illegal encodings never enter the pipe
   a_legal_accept : assert property (@(posedge clk_i) disable iff (!rst_i)
      advance_i && in_valid_i |->
         sew_i inside {SEW8, SEW16, SEW32} &&
         op2_sel_i inside {SRC_VS2, SRC_X, SRC_IMM} &&
         op_i inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLIDEUP, OP_SLIDEDN});

endmodule

// File: design/vdpu_pkg.sv
`include "vdpu_settings.svh"

package vdpu_pkg;

   //////////////////////////////////////////////////
   // Instruction encodings
   //////////////////////////////////////////////////

   typedef enum logic [1:0] {
      SEW8  = 2'd0,
      SEW16 = 2'd1,
      SEW32 = 2'd2   // Code 3 is illegal
   } sew_e;

   typedef enum logic [2:0] {
      OP_ADD     = 3'd0,
      OP_SUB     = 3'd1,
      OP_AND     = 3'd2,
      OP_OR      = 3'd3,
      OP_XOR     = 3'd4,
      OP_SLIDEUP = 3'd5,
      OP_SLIDEDN = 3'd6
   } alu_op_e;

   // Source of operand b
   typedef enum logic [1:0] {
      SRC_VS2 = 2'd0,
      SRC_X   = 2'd1,
      SRC_IMM = 2'd2
   } op2_sel_e;

   // Lane word, whole or as bytes 0..3
   typedef union packed {
      logic [`VDPU_WORD_W-1:0] word;
      logic [3:0][7:0]         bytes;
   } lane_word_u;

   typedef lane_word_u [`VDPU_LANES-1:0] lane_vec_t;   // Lane 0 in the low word

endpackage

// File: design/vdpu_settings.svh
`ifndef VDPU_SETTINGS_SVH
`define VDPU_SETTINGS_SVH

//////////////////////////////////////////////////
// Datapath geometry
//////////////////////////////////////////////////

`define VDPU_LANES   8    // Lanes in the vector unit
`define VDPU_WORD_W  32   // One lane word
`define VDPU_IMM_W   5

// log2 of the lane count
`define VDPU_SLIDE_W 3

`endif
